//--- sources.f
common/cpuPkg.sv
control/controlFsm.sv
src/pcCounter.sv
src/regFile.sv
src/alu.sv
src/memInterface.sv
src/cpuTop.sv
dv/tbClock.sv
dv/cpuAssert.sv
dv/cpuTb.sv

//--- Bender.yml
package:
  name: mips_multicycle_cpu

sources:
  - common/cpuPkg.sv
  - control/controlFsm.sv
  - src/pcCounter.sv
  - src/regFile.sv
  - src/alu.sv
  - src/memInterface.sv
  - src/cpuTop.sv
  - target: test
    files:
      - dv/tbClock.sv
      - dv/cpuAssert.sv
      - dv/cpuTb.sv

//--- dv/cpuTb.sv
`default_nettype none

module cpuTb import cpuPkg::*; ();

  localparam int NumInstr      = 400;
  localparam int MaxWait       = 3;
  localparam int ResetCycles   = 10;
  localparam int TimeoutCycles = NumInstr * (5 + 2 * MaxWait) + ResetCycles;
  // words 0..127 hold code, 128..255 hold data
  localparam int ProgWords     = 128;

  logic  Clk;
  logic  rst;
  word_t wbDatI;
  logic  wbAck;
  logic  wbCyc;
  logic  wbStb;
  logic  wbWe;
  word_t wbAdr;
  word_t wbDatO;

  // slave memory and the model's own copy
  word_t mem [0:255];
  word_t refMem [0:255];
  word_t refRegs [0:31];
  word_t refPc;

  // predicted transactions oldest first
  word_t expAdr [$];
  logic  expWe [$];
  word_t expDat [$];
  logic  expFetch [$];

  int errorCount = 0;
  int fetchCount = 0;
  int cycleCount = 0;
  int waitLeft;
  logic pending;

  tbClock uClock (
    .Clk (Clk)
  );

  cpuTop DUT (
    .Clk    (Clk),
    .rst    (rst),
    .wbDatI (wbDatI),
    .wbAck  (wbAck),
    .wbCyc  (wbCyc),
    .wbStb  (wbStb),
    .wbWe   (wbWe),
    .wbAdr  (wbAdr),
    .wbDatO (wbDatO)
  );

  task automatic checkValue(input string name, input word_t actual, input word_t expected);
    if (actual !== expected) begin
      errorCount++;
      $display("Fail %s: got %h, expected %h", name, actual, expected);
    end
  endtask

  // random instruction for one program slot
  function automatic word_t randomInstr(input int slot);
    regAddr_t rs;
    regAddr_t rt;
    regAddr_t dest;
    int reach;
    int target;
    logic [15:0] offset;
    logic useR7;
    opcode_t op;
    funct_t fn;
    word_t ins;
    rs = regAddr_t'($urandom_range(0, 7));
    rt = regAddr_t'($urandom_range(0, 7));
    // r7 holds the data base pointer and is never a destination
    dest = regAddr_t'($urandom_range(0, 6));
    // forward targets only within 8 words
    reach = (ProgWords - 1 - slot < 8) ? ProgWords - 1 - slot : 8;
    target = slot + 1 + int'($urandom_range(0, reach - 1));
    offset = 16'(4 * $urandom_range(0, 127));
    useR7 = 1'($urandom_range(0, 1));
    case ($urandom_range(0, 11))
      0: ins = {OpRType, rs, rt, dest, 5'd0, FnAddu};
      1: ins = {OpRType, rs, rt, dest, 5'd0, FnSubu};
      2: ins = {OpRType, rs, rt, dest, 5'd0, FnAnd};
      3: ins = {OpRType, rs, rt, dest, 5'd0, FnOr};
      4: ins = {OpRType, rs, rt, dest, 5'd0, FnSlt};
      5: ins = {OpAddiu, rs, dest, 16'($urandom())};
      // r7 base plus offset, or r0 plus an absolute data address
      6: ins = useR7 ? {OpLw, 5'd7, dest, offset} : {OpLw, 5'd0, dest, offset + 16'h0200};
      7: ins = useR7 ? {OpSw, 5'd7, rt, offset} : {OpSw, 5'd0, rt, offset + 16'h0200};
      8: ins = {OpBeq, rs, rt, 16'(target - slot - 1)};
      9: ins = {OpJ, 26'(target)};
      10: begin
        // opcode outside the supported set
        do begin
          op = opcode_t'($urandom_range(0, 63));
        end while (op inside {OpRType, OpAddiu, OpLw, OpSw, OpBeq, OpJ});
        ins = {op, 26'($urandom())};
      end
      default: begin
        do begin
          fn = funct_t'($urandom_range(0, 63));
        end while (fn inside {FnAddu, FnSubu, FnAnd, FnOr, FnSlt});
        ins = {OpRType, rs, rt, dest, 5'd0, fn};
      end
    endcase
    return ins;
  endfunction

  task automatic pushAccess(input word_t adr, input logic we, input word_t dat, input logic fetch);
    expAdr.push_back(adr);
    expWe.push_back(we);
    expDat.push_back(dat);
    expFetch.push_back(fetch);
  endtask

  task automatic writeReg(input regAddr_t idx, input word_t value);
    // r0 stays zero
    if (idx != 5'd0) begin
      refRegs[idx] = value;
    end
  endtask

  // reference model stepping one whole instruction per call
  task automatic stepModel();
    word_t ins;
    word_t a;
    word_t b;
    word_t simm;
    word_t nextPc;
    word_t adr;
    ins = refMem[refPc[9:2]];
    a = refRegs[ins[25:21]];
    b = refRegs[ins[20:16]];
    simm = {{16{ins[15]}}, ins[15:0]};
    nextPc = refPc + 32'd4;
    pushAccess(refPc, 1'b0, 32'd0, 1'b1);
    case (ins[31:26])
      OpRType: begin
        case (ins[5:0])
          FnAddu: writeReg(ins[15:11], a + b);
          FnSubu: writeReg(ins[15:11], a - b);
          FnAnd:  writeReg(ins[15:11], a & b);
          FnOr:   writeReg(ins[15:11], a | b);
          FnSlt:  writeReg(ins[15:11], ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
          default: ;
        endcase
      end
      OpAddiu: writeReg(ins[20:16], a + simm);
      OpLw: begin
        adr = a + simm;
        pushAccess(adr, 1'b0, 32'd0, 1'b0);
        writeReg(ins[20:16], refMem[adr[9:2]]);
      end
      OpSw: begin
        adr = a + simm;
        pushAccess(adr, 1'b1, b, 1'b0);
        refMem[adr[9:2]] = b;
      end
      OpBeq: begin
        if (a == b) begin
          nextPc = nextPc + {simm[29:0], 2'b00};
        end
      end
      OpJ: nextPc = {nextPc[31:28], ins[25:0], 2'b00};
      // unknown encodings only move the pc
      default: ;
    endcase
    refPc = nextPc;
  endtask

  // compare one ack against the prediction, then do the access
  task automatic serviceAccess();
    word_t eAdr;
    word_t eDat;
    logic eWe;
    logic eFetch;
    if (expAdr.size() == 0) begin
      stepModel();
    end
    eAdr = expAdr.pop_front();
    eWe = expWe.pop_front();
    eDat = expDat.pop_front();
    eFetch = expFetch.pop_front();
    checkValue("wbAdr", wbAdr, eAdr);
    checkValue("wbWe", {31'd0, wbWe}, {31'd0, eWe});
    if (eWe) begin
      checkValue("wbDatO", wbDatO, eDat);
    end
    if (eFetch) begin
      fetchCount++;
    end
    // slave wraps at 256 words
    if (wbWe) begin
      mem[wbAdr[9:2]] = wbDatO;
    end else begin
      wbDatI = mem[wbAdr[9:2]];
    end
  endtask

  // wishbone slave with 0 to 3 wait cycles per access
  always @(negedge Clk) begin
    if (rst) begin
      wbAck = 1'b0;
      pending = 1'b0;
    end else if (wbAck) begin
      // master closed the cycle on the last rising edge
      checkValue("wbCyc", {31'd0, wbCyc}, 32'd0);
      checkValue("wbStb", {31'd0, wbStb}, 32'd0);
      wbAck = 1'b0;
    end else if (wbCyc && wbStb) begin
      if (!pending) begin
        pending = 1'b1;
        waitLeft = $urandom_range(0, MaxWait);
      end
      if (waitLeft == 0) begin
        serviceAccess();
        wbAck = 1'b1;
        pending = 1'b0;
      end else begin
        waitLeft--;
      end
    end
  end

  initial begin
    word_t w;
    int assertFails;
    rst = 1'b1;
    wbAck = 1'b0;
    wbDatI = 32'd0;
    pending = 1'b0;
    waitLeft = 0;
    void'($urandom(32'h049ad2ea));
    // slot 0 sets the r7 data pointer and the last slot loops back to 0
    for (int i = 0; i < 256; i++) begin
      if (i == 0) begin
        w = {OpAddiu, 5'd0, 5'd7, 16'h0200};
      end else if (i == ProgWords - 1) begin
        w = {OpJ, 26'd0};
      end else if (i < ProgWords) begin
        w = randomInstr(i);
      end else begin
        w = $urandom();
      end
      mem[i] = w;
      refMem[i] = w;
    end
    for (int i = 0; i < 32; i++) begin
      refRegs[i] = 32'd0;
    end
    // first fetch from address 0
    refPc = 32'd0;
    repeat (ResetCycles) @(posedge Clk);
    @(negedge Clk);
    rst = 1'b0;
    // one extra fetch confirms the pc after the last instruction
    while (fetchCount <= NumInstr && cycleCount < TimeoutCycles) begin
      @(posedge Clk);
      cycleCount++;
    end
    if (fetchCount <= NumInstr) begin
      errorCount++;
      $display("timeout after %0d cycles, only %0d instructions fetched",
               cycleCount, fetchCount);
    end
    assertFails = DUT.uMemInterface.uCpuAssert.assertFails;
    $display("errors: %0d check, %0d assertion, %0d instructions run",
             errorCount, assertFails, fetchCount - 1);
    if (errorCount == 0 && assertFails == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/cpuAssert.sv
`default_nettype none

module cpuAssert import cpuPkg::*; (
  input  wire        Clk,
  input  wire        rst,
  input  wire        wbCyc,
  input  wire        wbStb,
  input  wire        wbWe,
  input  wire        wbAck,
  input  wire word_t wbAdr,
  input  wire word_t wbDatO
);

  // read back by the testbench at the end of the run
  int assertFails = 0;

  // a strobe outside a bus cycle is illegal
  stbInsideCyc: assert property (@(posedge Clk) disable iff (rst) wbStb |-> wbCyc)
    else begin
      assertFails++;
      $error("wishbone stb high while cyc is low");
    end

  // request held steady through wait states
  reqStable: assert property (@(posedge Clk) disable iff (rst)
    (wbStb && !wbAck) |=> ($stable(wbAdr) && $stable(wbWe) && $stable(wbDatO)))
    else begin
      assertFails++;
      $error("wishbone request changed before ack");
    end

  // no bus cycle right after a reset edge
  cycLowAfterReset: assert property (@(posedge Clk) rst |=> !wbCyc)
    else begin
      assertFails++;
      $error("wishbone cyc high in the cycle after reset");
    end

endmodule

bind memInterface cpuAssert uCpuAssert (
  .Clk    (Clk),
  .rst    (rst),
  .wbCyc  (wbCyc),
  .wbStb  (wbStb),
  .wbWe   (wbWe),
  .wbAck  (wbAck),
  .wbAdr  (wbAdr),
  .wbDatO (wbDatO)
);

`default_nettype wire

//--- dv/tbClock.sv
`default_nettype none

module tbClock (
  output logic Clk
);

  // 40 unit period, starts low
  initial begin
    Clk = 1'b0;
    forever begin
      #20 Clk = ~Clk;
    end
  end

endmodule

`default_nettype wire

//--- src/cpuTop.sv
`default_nettype none

module cpuTop import cpuPkg::*; (
  input  wire        Clk,
  input  wire        rst,
  input  wire word_t wbDatI,
  input  wire        wbAck,
  output logic       wbCyc,
  output logic       wbStb,
  output logic       wbWe,
  output word_t      wbAdr,
  output word_t      wbDatO
);

  // fsm to bus
  logic busReq;
  logic busWrite;
  logic addrFromAlu;
  logic irLoad;
  logic mdrLoad;
  logic busDone;

  // fsm to datapath
  logic     regWrite;
  regAddr_t writeSel;
  logic     writeFromMem;
  aluOp_t   aluOp;
  word_t    aluA;
  word_t    aluB;
  logic     pcStep;
  logic     branchTaken;
  logic     jumpTaken;

  word_t    instr;
  word_t    mdr;
  word_t    pc;
  word_t    aluResult;
  logic     aluZero;
  regAddr_t rsAddr;
  regAddr_t rtAddr;
  word_t    rsData;
  word_t    rtData;
  word_t    writeData;

  assign rsAddr = instr[25:21];
  assign rtAddr = instr[20:16];
  // alu operands are held in the fsm, so the result is still valid in writeback
  assign writeData = writeFromMem ? mdr : aluResult;

  controlFsm uControlFsm (
    .Clk          (Clk),
    .rst          (rst),
    .instr        (instr),
    .busDone      (busDone),
    .aluZero      (aluZero),
    .rsData       (rsData),
    .rtData       (rtData),
    .busReq       (busReq),
    .busWrite     (busWrite),
    .addrFromAlu  (addrFromAlu),
    .irLoad       (irLoad),
    .mdrLoad      (mdrLoad),
    .regWrite     (regWrite),
    .writeSel     (writeSel),
    .writeFromMem (writeFromMem),
    .aluOp        (aluOp),
    .aluA         (aluA),
    .aluB         (aluB),
    .pcStep       (pcStep),
    .branchTaken  (branchTaken),
    .jumpTaken    (jumpTaken)
  );

  pcCounter uPcCounter (
    .Clk         (Clk),
    .rst         (rst),
    .pcStep      (pcStep),
    .branchTaken (branchTaken),
    .jumpTaken   (jumpTaken),
    .instr       (instr),
    .pc          (pc)
  );

  regFile uRegFile (
    .Clk       (Clk),
    .rst       (rst),
    .rsAddr    (rsAddr),
    .rtAddr    (rtAddr),
    .writeEn   (regWrite),
    .writeAddr (writeSel),
    .writeData (writeData),
    .rsData    (rsData),
    .rtData    (rtData)
  );

  alu uAlu (
    .aluOp  (aluOp),
    .a      (aluA),
    .b      (aluB),
    .result (aluResult),
    .zero   (aluZero)
  );

  // sw data is rt straight from the register file
  memInterface uMemInterface (
    .Clk         (Clk),
    .rst         (rst),
    .busReq      (busReq),
    .busWrite    (busWrite),
    .addrFromAlu (addrFromAlu),
    .irLoad      (irLoad),
    .mdrLoad     (mdrLoad),
    .pc          (pc),
    .aluResult   (aluResult),
    .storeData   (rtData),
    .wbDatI      (wbDatI),
    .wbAck       (wbAck),
    .busDone     (busDone),
    .instr       (instr),
    .mdr         (mdr),
    .wbCyc       (wbCyc),
    .wbStb       (wbStb),
    .wbWe        (wbWe),
    .wbAdr       (wbAdr),
    .wbDatO      (wbDatO)
  );

endmodule

`default_nettype wire

//--- src/memInterface.sv
`default_nettype none

module memInterface import cpuPkg::*; (
  input  wire        Clk,
  input  wire        rst,
  input  wire        busReq,
  input  wire        busWrite,
  input  wire        addrFromAlu,
  input  wire        irLoad,
  input  wire        mdrLoad,
  input  wire word_t pc,
  input  wire word_t aluResult,
  input  wire word_t storeData,
  input  wire word_t wbDatI,
  input  wire        wbAck,
  output logic       busDone,
  output word_t      instr,
  output word_t      mdr,
  output logic       wbCyc,
  output logic       wbStb,
  output logic       wbWe,
  output word_t      wbAdr,
  output word_t      wbDatO
);

  // cyc and stb always move together
  logic busActive;
  logic busStart;
  // current access uses the latched data address
  logic dataPhase;
  logic weReg;
  word_t dataAdr;
  word_t datOReg;

  assign busStart = busReq & !busActive;
  // one pulse, the ack cycle
  assign busDone  = busActive & wbAck;

  always_ff @(posedge Clk) begin
    if (rst) begin
      busActive <= 1'b0;
      weReg     <= 1'b0;
      dataPhase <= 1'b0;
    end else if (busDone) begin
      // drop the cycle as soon as ack is seen
      busActive <= 1'b0;
      weReg     <= 1'b0;
    end else if (busStart) begin
      busActive <= 1'b1;
      weReg     <= busWrite;
      dataPhase <= addrFromAlu;
    end
  end

  // lw/sw address and store data, held until ack
  always_ff @(posedge Clk) begin
    if (busStart) begin
      dataAdr <= aluResult;
      datOReg <= storeData;
    end
  end

  // ir and mdr capture the read data on ack
  always_ff @(posedge Clk) begin
    if (busDone && irLoad) begin
      instr <= wbDatI;
    end
  end

  always_ff @(posedge Clk) begin
    if (busDone && mdrLoad) begin
      mdr <= wbDatI;
    end
  end

  assign wbCyc  = busActive;
  assign wbStb  = busActive;
  assign wbWe   = weReg;
  // fetches use the pc directly, it only moves at the end of writeback
  assign wbAdr  = dataPhase ? dataAdr : pc;
  assign wbDatO = datOReg;

endmodule

`default_nettype wire

//--- src/alu.sv
`default_nettype none

module alu import cpuPkg::*; (
  input  wire aluOp_t aluOp,
  input  wire word_t  a,
  input  wire word_t  b,
  output word_t       result,
  output logic        zero
);

  // signed compare for slt
  logic lessThan;

  assign lessThan = $signed(a) < $signed(b);

  always_comb begin
    case (aluOp)
      // addu and subu wrap, no overflow trap
      AluAdd: result = a + b;
      AluSub: result = a - b;
      AluAnd: result = a & b;
      AluOr:  result = a | b;
      AluSlt: result = {31'd0, lessThan};
      default: result = '0;
    endcase
  end

  // beq compares through a subtraction
  assign zero = (result == '0);

endmodule

`default_nettype wire

//--- src/regFile.sv
`default_nettype none

module regFile import cpuPkg::*; (
  input  wire           Clk,
  input  wire           rst,
  input  wire regAddr_t rsAddr,
  input  wire regAddr_t rtAddr,
  input  wire           writeEn,
  input  wire regAddr_t writeAddr,
  input  wire word_t    writeData,
  output word_t         rsData,
  output word_t         rtData
);

  word_t regs [0:31];

  always_ff @(posedge Clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn && (writeAddr != '0)) begin
      // r0 is never written
      regs[writeAddr] <= writeData;
    end
  end

  // combinational reads, r0 forced to zero
  assign rsData = (rsAddr == '0) ? '0 : regs[rsAddr];
  assign rtData = (rtAddr == '0) ? '0 : regs[rtAddr];

endmodule

`default_nettype wire

//--- src/pcCounter.sv
`default_nettype none

module pcCounter import cpuPkg::*; (
  input  wire        Clk,
  input  wire        rst,
  input  wire        pcStep,
  input  wire        branchTaken,
  input  wire        jumpTaken,
  input  wire word_t instr,
  output word_t      pc
);

  word_t pcPlus4;
  word_t branchTarget;
  word_t jumpTarget;

  assign pcPlus4 = pc + 32'd4;
  // offset counts words, relative to the next instruction
  assign branchTarget = pcPlus4 + {{14{instr[15]}}, instr[15:0], 2'b00};
  // stays inside the current 256 MB region
  assign jumpTarget = {pcPlus4[31:28], instr[25:0], 2'b00};

  always_ff @(posedge Clk) begin
    if (rst) begin
      pc <= ResetPc;
    end else if (pcStep) begin
      // jump wins, both are never set together
      if (jumpTaken) begin
        pc <= jumpTarget;
      end else if (branchTaken) begin
        pc <= branchTarget;
      end else begin
        pc <= pcPlus4;
      end
    end
  end

endmodule

`default_nettype wire

//--- control/controlFsm.sv
`default_nettype none

module controlFsm import cpuPkg::*; (
  input  wire        Clk,
  input  wire        rst,
  input  wire word_t instr,
  input  wire        busDone,
  input  wire        aluZero,
  input  wire word_t rsData,
  input  wire word_t rtData,
  output logic       busReq,
  output logic       busWrite,
  output logic       addrFromAlu,
  output logic       irLoad,
  output logic       mdrLoad,
  output logic       regWrite,
  output regAddr_t   writeSel,
  output logic       writeFromMem,
  output aluOp_t     aluOp,
  output word_t      aluA,
  output word_t      aluB,
  output logic       pcStep,
  output logic       branchTaken,
  output logic       jumpTaken
);

  ctrlState_t state;
  ctrlState_t nextState;

  // operand holding registers, loaded at the end of decode
  word_t aReg;
  word_t bReg;

  // low only in the first cycle out of reset
  logic bootDone;

  opcode_t opcode;
  funct_t  funct;
  word_t   immExt;

  // instruction class flags
  logic rValid;
  logic isAddiu;
  logic isLw;
  logic isSw;
  logic isBeq;
  logic isJ;
  logic isMem;
  logic useImm;
  logic writesReg;

  assign opcode = instr[31:26];
  assign funct  = instr[5:0];
  // addiu, lw, sw and beq all sign-extend
  assign immExt = {{16{instr[15]}}, instr[15:0]};

  // decode of the held instruction register
  always_comb begin
    rValid  = 1'b0;
    isAddiu = 1'b0;
    isLw    = 1'b0;
    isSw    = 1'b0;
    isBeq   = 1'b0;
    isJ     = 1'b0;
    aluOp   = AluAdd;
    case (opcode)
      OpRType: begin
        rValid = 1'b1;
        case (funct)
          FnAddu: aluOp = AluAdd;
          FnSubu: aluOp = AluSub;
          FnAnd:  aluOp = AluAnd;
          FnOr:   aluOp = AluOr;
          FnSlt:  aluOp = AluSlt;
          // unknown funct just advances the pc
          default: rValid = 1'b0;
        endcase
      end
      OpAddiu: isAddiu = 1'b1;
      OpLw:    isLw = 1'b1;
      OpSw:    isSw = 1'b1;
      OpBeq: begin
        isBeq = 1'b1;
        // equal when a - b is zero
        aluOp = AluSub;
      end
      OpJ:     isJ = 1'b1;
      default: ;
    endcase
  end

  assign isMem     = isLw | isSw;
  assign useImm    = isAddiu | isMem;
  assign writesReg = rValid | isAddiu | isLw;

  // rd for r-type, rt otherwise
  assign writeSel     = rValid ? instr[15:11] : instr[20:16];
  assign writeFromMem = isLw;

  // alu operands come from the held registers
  assign aluA = aReg;
  assign aluB = useImm ? immExt : bReg;

  always_ff @(posedge Clk) begin
    if (rst) begin
      state    <= Fetch;
      bootDone <= 1'b0;
    end else begin
      state    <= nextState;
      bootDone <= 1'b1;
    end
  end

  // rs and rt are valid in decode, ir was loaded on the fetch ack
  always_ff @(posedge Clk) begin
    if (state == Decode) begin
      aReg <= rsData;
      bReg <= rtData;
    end
  end

  always_comb begin
    nextState   = state;
    busReq      = 1'b0;
    busWrite    = 1'b0;
    addrFromAlu = 1'b0;
    irLoad      = 1'b0;
    mdrLoad     = 1'b0;
    regWrite    = 1'b0;
    pcStep      = 1'b0;
    branchTaken = 1'b0;
    jumpTaken   = 1'b0;
    case (state)
      Fetch: begin
        // out of reset nothing has been requested yet
        busReq = !bootDone;
        irLoad = 1'b1;
        if (busDone) begin
          nextState = Decode;
        end
      end
      Decode: nextState = Execute;
      Execute: begin
        if (isMem) begin
          // address is base + offset from the alu
          busReq      = 1'b1;
          busWrite    = isSw;
          addrFromAlu = 1'b1;
          nextState   = MemAccess;
        end else begin
          nextState = WriteBack;
        end
      end
      MemAccess: begin
        mdrLoad = isLw;
        // hold until the slave acks
        if (busDone) begin
          nextState = WriteBack;
        end
      end
      WriteBack: begin
        regWrite    = writesReg;
        pcStep      = 1'b1;
        branchTaken = isBeq & aluZero;
        jumpTaken   = isJ;
        // next fetch starts on the same edge the pc steps
        busReq      = 1'b1;
        nextState   = Fetch;
      end
      default: nextState = Fetch;
    endcase
  end

endmodule

`default_nettype wire

//--- common/cpuPkg.sv
`default_nettype none

package cpuPkg;

  // one machine word, used for data, addresses and the pc
  typedef logic [31:0] word_t;
  // register index, 32 registers
  typedef logic [4:0]  regAddr_t;
  // instr[31:26]
  typedef logic [5:0]  opcode_t;
  // instr[5:0], only meaningful for r-type
  typedef logic [5:0]  funct_t;
  typedef logic [2:0]  aluOp_t;

  // primary opcodes
  localparam opcode_t OpRType = 6'b000000;
  localparam opcode_t OpAddiu = 6'b001001;
  localparam opcode_t OpLw    = 6'b100011;
  localparam opcode_t OpSw    = 6'b101011;
  localparam opcode_t OpBeq   = 6'b000100;
  localparam opcode_t OpJ     = 6'b000010;

  // r-type function codes
  localparam funct_t FnAddu = 6'b100001;
  localparam funct_t FnSubu = 6'b100011;
  localparam funct_t FnAnd  = 6'b100100;
  localparam funct_t FnOr   = 6'b100101;
  localparam funct_t FnSlt  = 6'b101010;

  // alu operation select
  localparam aluOp_t AluAdd = 3'd0;
  localparam aluOp_t AluSub = 3'd1;
  localparam aluOp_t AluAnd = 3'd2;
  localparam aluOp_t AluOr  = 3'd3;
  // signed compare, result is 0 or 1
  localparam aluOp_t AluSlt = 3'd4;

  // multi-cycle control sequence
  typedef enum logic [2:0] {
    Fetch,
    Decode,
    Execute,
    MemAccess,
    WriteBack
  } ctrlState_t;

  // first fetch address
  localparam word_t ResetPc = 32'h0000_0000;

endpackage

`default_nettype wire
